// ==== common/zynq_shell_pkg.sv ====
`default_nettype none

package zynq_shell_pkg;

   // ----------------------------------------
   // bus geometry
   // ----------------------------------------

   localparam int data_width_lp = 32;
   localparam int addr_width_lp = 5;
   // byte offset bits sit below the word index
   localparam int addr_lsb_lp = 2;
   localparam int word_idx_width_lp = addr_width_lp - addr_lsb_lp;

   // only OKAY is ever returned on B and R
   localparam logic [1:0] resp_okay_lp = 2'b00;

   typedef logic [data_width_lp-1:0] word_t;
   typedef logic [word_idx_width_lp-1:0] word_idx_t;

   // ----------------------------------------
   // fifo sizing
   // ----------------------------------------

   localparam int fifo_depth_lp = 4;
   localparam int fifo_ptr_width_lp = $clog2(fifo_depth_lp);

   typedef logic [fifo_ptr_width_lp-1:0] fifo_ptr_t;
   // one extra bit so a full fifo can count to depth
   typedef logic [fifo_ptr_width_lp:0] fifo_count_t;

   localparam int num_ctrl_regs_lp = 2;
   // words visible to reads, 6 and 7 fall outside and read zero
   localparam int num_rd_words_lp = 6;

   // ----------------------------------------
   // address map, in word indices
   // ----------------------------------------

   // read side
   localparam word_idx_t rd_ctrl0_lp = 3'd0;
   localparam word_idx_t rd_ctrl1_lp = 3'd1;
   localparam word_idx_t rd_pl_fifo_head_lp = 3'd2;
   localparam word_idx_t rd_pl_fifo_count_lp = 3'd3;
   localparam word_idx_t rd_ps_fifo_free_lp = 3'd4;
   localparam word_idx_t rd_status_lp = 3'd5;

   // write side, anything else is acked and dropped
   localparam word_idx_t wr_ctrl0_lp = 3'd0;
   localparam word_idx_t wr_ctrl1_lp = 3'd1;
   localparam word_idx_t wr_ps_fifo_push_lp = 3'd2;

   // one accepted write transfer
   typedef struct packed {
      logic v;
      word_idx_t idx;
      word_t data;
   } wr_req_t;

   // one accepted read transfer
   typedef struct packed {
      logic v;
      word_idx_t idx;
   } rd_req_t;

endpackage

`default_nettype wire

// ==== hw/axil/axil_write_channel.sv ====
`default_nettype none
`timescale 1ns/10ps

module axil_write_channel
   import zynq_shell_pkg::*;
(
   input  logic                     S_AXI_ACLK,
   input  logic                     S_AXI_ARESETN,
   input  logic [addr_width_lp-1:0] awaddr_i,
   input  logic                     awvalid_i,
   output logic                     awready_o,
   input  logic [data_width_lp-1:0] wdata_i,
   input  logic                     wvalid_i,
   output logic                     wready_o,
   output logic [1:0]               bresp_o,
   output logic                     bvalid_o,
   input  logic                     bready_i,
   output wr_req_t                  wr_req_o
);

   // aw_en low means a write is in flight and its response not yet taken
   logic aw_en_r;
   // AWREADY and WREADY always pulse together
   logic ready_r;
   logic bvalid_r;
   word_idx_t idx_r;

   logic accept;
   logic handshake;
   logic resp_done;

   // both address and data present, nothing outstanding
   assign accept = ~ready_r & awvalid_i & wvalid_i & aw_en_r;
   // the single cycle where the transfer actually completes
   assign handshake = ready_r & awvalid_i & wvalid_i;
   assign resp_done = bvalid_r & bready_i;

   // ----------------------------------------
   // ready pulse and single outstanding gate
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         ready_r <= 1'b0;
         aw_en_r <= 1'b1;
      end
      else
      begin
         ready_r <= accept;
         if (accept)
            aw_en_r <= 1'b0;
         else if (resp_done)
            aw_en_r <= 1'b1;
      end
   end

   // word index taken when the ready pulse is launched
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (accept)
         idx_r <= awaddr_i[addr_lsb_lp +: word_idx_width_lp];
   end

   // ----------------------------------------
   // write response
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         bvalid_r <= 1'b0;
      else if (handshake && !bvalid_r)
         bvalid_r <= 1'b1;
      else if (resp_done)
         bvalid_r <= 1'b0;
   end

   assign awready_o = ready_r;
   assign wready_o = ready_r;
   assign bvalid_o = bvalid_r;
   assign bresp_o = resp_okay_lp;

   // request to the map, data comes straight off the W channel
   assign wr_req_o.v = handshake;
   assign wr_req_o.idx = idx_r;
   assign wr_req_o.data = wdata_i;

endmodule

`default_nettype wire

// ==== hw/axil/axil_read_channel.sv ====
`default_nettype none
`timescale 1ns/10ps

module axil_read_channel
   import zynq_shell_pkg::*;
(
   input  logic                     S_AXI_ACLK,
   input  logic                     S_AXI_ARESETN,
   input  logic [addr_width_lp-1:0] araddr_i,
   input  logic                     arvalid_i,
   output logic                     arready_o,
   output logic [data_width_lp-1:0] rdata_o,
   output logic [1:0]               rresp_o,
   output logic                     rvalid_o,
   input  logic                     rready_i,
   output rd_req_t                  rd_req_o,
   input  word_t                    rd_data_i
);

   logic arready_r;
   logic rvalid_r;
   word_idx_t idx_r;
   word_t rdata_r;

   logic accept;
   logic rd_fire;

   // hold off a new address while a response is still waiting
   assign accept = ~arready_r & arvalid_i & ~rvalid_r;
   assign rd_fire = arready_r & arvalid_i & ~rvalid_r;

   // ----------------------------------------
   // address phase
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         arready_r <= 1'b0;
      else
         arready_r <= accept;
   end

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (accept)
         idx_r <= araddr_i[addr_lsb_lp +: word_idx_width_lp];
   end

   // ----------------------------------------
   // data phase
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         rvalid_r <= 1'b0;
      else if (rd_fire)
         rvalid_r <= 1'b1;
      else if (rvalid_r && rready_i)
         rvalid_r <= 1'b0;
   end

   // word from the map is sampled in the handshake cycle and held
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (rd_fire)
         rdata_r <= rd_data_i;
   end

   assign arready_o = arready_r;
   assign rvalid_o = rvalid_r;
   assign rdata_o = rdata_r;
   assign rresp_o = resp_okay_lp;

   assign rd_req_o.v = rd_fire;
   assign rd_req_o.idx = idx_r;

endmodule

`default_nettype wire

// ==== hw/word_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module word_fifo
   import zynq_shell_pkg::*;
(
   input  logic        S_AXI_ACLK,
   input  logic        S_AXI_ARESETN,
   // input side, valid/ready
   input  logic        v_i,
   output logic        ready_o,
   input  word_t       data_i,
   // output side, valid/yumi
   output logic        v_o,
   output word_t       data_o,
   input  logic        yumi_i,
   output fifo_count_t count_o
);

   word_t mem_r [fifo_depth_lp];
   fifo_ptr_t wr_ptr_r;
   fifo_ptr_t rd_ptr_r;
   fifo_count_t count_r;

   logic push;
   logic pop;

   // ready depends only on occupancy, never on yumi
   assign ready_o = (count_r < fifo_count_t'(fifo_depth_lp));
   assign v_o = (count_r != '0);
   assign push = v_i & ready_o;
   // yumi is only legal while v_o is high
   assign pop = yumi_i;

   // ----------------------------------------
   // storage
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (push)
         mem_r[wr_ptr_r] <= data_i;
   end

   // head is read combinationally
   assign data_o = mem_r[rd_ptr_r];

   // ----------------------------------------
   // pointers and occupancy
   // ----------------------------------------

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r <= '0;
      end
      else
      begin
         // pointers wrap on their own since depth is a power of two
         if (push)
            wr_ptr_r <= wr_ptr_r + fifo_ptr_t'(1);
         if (pop)
            rd_ptr_r <= rd_ptr_r + fifo_ptr_t'(1);
         case ({push, pop})
            2'b10: count_r <= count_r + fifo_count_t'(1);
            2'b01: count_r <= count_r - fifo_count_t'(1);
            // push and pop together leave the count alone
            default: count_r <= count_r;
         endcase
      end
   end

   assign count_o = count_r;

endmodule

`default_nettype wire

// ==== hw/csr_map.sv ====
`default_nettype none
`timescale 1ns/10ps

module csr_map
   import zynq_shell_pkg::*;
(
   input  logic                               S_AXI_ACLK,
   input  logic                               S_AXI_ARESETN,
   input  wr_req_t                            wr_req_i,
   input  rd_req_t                            rd_req_i,
   output word_t                              rd_data_o,
   output word_t [num_ctrl_regs_lp-1:0]       csr_data_o,
   output logic  [num_ctrl_regs_lp-1:0]       csr_data_new_o,
   input  word_t                              status_i,
   // fifo toward the logic
   output logic                               ps_push_o,
   input  logic                               ps_ready_i,
   input  fifo_count_t                        ps_count_i,
   // fifo toward the processor
   input  word_t                              pl_head_i,
   input  logic                               pl_valid_i,
   output logic                               pl_pop_o,
   input  fifo_count_t                        pl_count_i
);

   word_t [num_ctrl_regs_lp-1:0] csr_r;
   logic [num_ctrl_regs_lp-1:0] csr_wr_en;
   logic [num_ctrl_regs_lp-1:0] csr_new_r;

   word_t [num_rd_words_lp-1:0] rd_words;
   logic [num_rd_words_lp-1:0] rd_sel;
   fifo_count_t ps_free;

   // ----------------------------------------
   // write decode
   // ----------------------------------------

   // control registers occupy write indices 0 and 1
   always_comb
   begin
      for (int k = 0; k < num_ctrl_regs_lp; k++)
         csr_wr_en[k] = wr_req_i.v && (wr_req_i.idx == word_idx_t'(k));
   end

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         csr_r <= '0;
         csr_new_r <= '0;
      end
      else
      begin
         for (int k = 0; k < num_ctrl_regs_lp; k++)
         begin
            if (csr_wr_en[k])
               csr_r[k] <= wr_req_i.data;
         end
         // new pulse lines up with the first cycle of the new value
         csr_new_r <= csr_wr_en;
      end
   end

   assign csr_data_o = csr_r;
   assign csr_data_new_o = csr_new_r;

   // writes into a full fifo are silently dropped
   assign ps_push_o = wr_req_i.v && (wr_req_i.idx == wr_ps_fifo_push_lp) && ps_ready_i;

   // ----------------------------------------
   // read decode and mux
   // ----------------------------------------

   assign ps_free = fifo_count_t'(fifo_depth_lp) - ps_count_i;

   // word order here is the read address map
   assign rd_words[rd_ctrl0_lp] = csr_r[0];
   assign rd_words[rd_ctrl1_lp] = csr_r[1];
   assign rd_words[rd_pl_fifo_head_lp] = pl_head_i;
   assign rd_words[rd_pl_fifo_count_lp] = word_t'(pl_count_i);
   assign rd_words[rd_ps_fifo_free_lp] = word_t'(ps_free);
   assign rd_words[rd_status_lp] = status_i;

   // one-hot select, empty for indices past the map
   always_comb
   begin
      for (int k = 0; k < num_rd_words_lp; k++)
         rd_sel[k] = rd_req_i.v && (rd_req_i.idx == word_idx_t'(k));
   end

   always_comb
   begin
      rd_data_o = '0;
      for (int k = 0; k < num_rd_words_lp; k++)
      begin
         if (rd_sel[k])
            rd_data_o = rd_data_o | rd_words[k];
      end
   end

   // only dequeue the head when there is one
   assign pl_pop_o = rd_sel[rd_pl_fifo_head_lp] & pl_valid_i;

endmodule

`default_nettype wire

// ==== hw/zynq_pl_shell.sv ====
`default_nettype none
`timescale 1ns/10ps

module zynq_pl_shell
   import zynq_shell_pkg::*;
(
   input  logic                           S_AXI_ACLK,
   input  logic                           S_AXI_ARESETN,
   // AXI4-Lite slave
   input  logic [addr_width_lp-1:0]       S_AXI_AWADDR,
   input  logic [2:0]                     S_AXI_AWPROT,
   input  logic                           S_AXI_AWVALID,
   output logic                           S_AXI_AWREADY,
   input  logic [data_width_lp-1:0]       S_AXI_WDATA,
   input  logic [(data_width_lp/8)-1:0]   S_AXI_WSTRB,
   input  logic                           S_AXI_WVALID,
   output logic                           S_AXI_WREADY,
   output logic [1:0]                     S_AXI_BRESP,
   output logic                           S_AXI_BVALID,
   input  logic                           S_AXI_BREADY,
   input  logic [addr_width_lp-1:0]       S_AXI_ARADDR,
   input  logic [2:0]                     S_AXI_ARPROT,
   input  logic                           S_AXI_ARVALID,
   output logic                           S_AXI_ARREADY,
   output logic [data_width_lp-1:0]       S_AXI_RDATA,
   output logic [1:0]                     S_AXI_RRESP,
   output logic                           S_AXI_RVALID,
   input  logic                           S_AXI_RREADY,
   // words from the processor into the logic
   output word_t                          ps_fifo_data_o,
   output logic                           ps_fifo_v_o,
   input  logic                           ps_fifo_yumi_i,
   // words from the logic up to the processor
   input  word_t                          pl_fifo_data_i,
   input  logic                           pl_fifo_v_i,
   output logic                           pl_fifo_ready_o,
   // control and status words
   output word_t [num_ctrl_regs_lp-1:0]   csr_data_o,
   output logic  [num_ctrl_regs_lp-1:0]   csr_data_new_o,
   input  word_t                          status_i
);

   wr_req_t wr_req;
   rd_req_t rd_req;
   word_t rd_data;

   logic ps_push;
   logic ps_ready;
   fifo_count_t ps_count;

   word_t pl_head;
   logic pl_valid;
   logic pl_pop;
   fifo_count_t pl_count;

   // ----------------------------------------
   // bus side
   // ----------------------------------------

   // AWPROT, ARPROT and WSTRB are not interpreted
   axil_write_channel i_wr_chan (
      .S_AXI_ACLK   (S_AXI_ACLK),
      .S_AXI_ARESETN(S_AXI_ARESETN),
      .awaddr_i     (S_AXI_AWADDR),
      .awvalid_i    (S_AXI_AWVALID),
      .awready_o    (S_AXI_AWREADY),
      .wdata_i      (S_AXI_WDATA),
      .wvalid_i     (S_AXI_WVALID),
      .wready_o     (S_AXI_WREADY),
      .bresp_o      (S_AXI_BRESP),
      .bvalid_o     (S_AXI_BVALID),
      .bready_i     (S_AXI_BREADY),
      .wr_req_o     (wr_req)
   );

   axil_read_channel i_rd_chan (
      .S_AXI_ACLK   (S_AXI_ACLK),
      .S_AXI_ARESETN(S_AXI_ARESETN),
      .araddr_i     (S_AXI_ARADDR),
      .arvalid_i    (S_AXI_ARVALID),
      .arready_o    (S_AXI_ARREADY),
      .rdata_o      (S_AXI_RDATA),
      .rresp_o      (S_AXI_RRESP),
      .rvalid_o     (S_AXI_RVALID),
      .rready_i     (S_AXI_RREADY),
      .rd_req_o     (rd_req),
      .rd_data_i    (rd_data)
   );

   csr_map i_csr_map (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .wr_req_i      (wr_req),
      .rd_req_i      (rd_req),
      .rd_data_o     (rd_data),
      .csr_data_o    (csr_data_o),
      .csr_data_new_o(csr_data_new_o),
      .status_i      (status_i),
      .ps_push_o     (ps_push),
      .ps_ready_i    (ps_ready),
      .ps_count_i    (ps_count),
      .pl_head_i     (pl_head),
      .pl_valid_i    (pl_valid),
      .pl_pop_o      (pl_pop),
      .pl_count_i    (pl_count)
   );

   // ----------------------------------------
   // logic side fifos
   // ----------------------------------------

   // push data is the W channel word of the current transfer
   word_fifo i_ps_fifo (
      .S_AXI_ACLK   (S_AXI_ACLK),
      .S_AXI_ARESETN(S_AXI_ARESETN),
      .v_i          (ps_push),
      .ready_o      (ps_ready),
      .data_i       (wr_req.data),
      .v_o          (ps_fifo_v_o),
      .data_o       (ps_fifo_data_o),
      .yumi_i       (ps_fifo_yumi_i),
      .count_o      (ps_count)
   );

   word_fifo i_pl_fifo (
      .S_AXI_ACLK   (S_AXI_ACLK),
      .S_AXI_ARESETN(S_AXI_ARESETN),
      .v_i          (pl_fifo_v_i),
      .ready_o      (pl_fifo_ready_o),
      .data_i       (pl_fifo_data_i),
      .v_o          (pl_valid),
      .data_o       (pl_head),
      .yumi_i       (pl_pop),
      .count_o      (pl_count)
   );

endmodule

`default_nettype wire

// ==== sim/zynq_pl_shell_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module zynq_pl_shell_props
   import zynq_shell_pkg::*;
(
   input logic        S_AXI_ACLK,
   input logic        S_AXI_ARESETN,
   input logic        awready_i,
   input logic        arready_i,
   input logic        bvalid_i,
   input logic        bready_i,
   input logic        rvalid_i,
   input logic        rready_i,
   input word_t       rdata_i,
   input logic        pl_pop_i,
   input fifo_count_t pl_count_i,
   input logic        ps_v_i,
   input logic        ps_yumi_i
);

   // ----------------------------------------
   // bus protocol
   // ----------------------------------------

   // ready is a single cycle pulse per transfer
   awready_pulse_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      awready_i |=> !awready_i)
   else $error("AWREADY stayed high for a second cycle");

   arready_pulse_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      arready_i |=> !arready_i)
   else $error("ARREADY stayed high for a second cycle");

   // responses wait for their ready
   bvalid_hold_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      bvalid_i && !bready_i |=> bvalid_i)
   else $error("BVALID dropped before BREADY");

   rvalid_hold_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
   else $error("RVALID or RDATA changed before RREADY");

   // ----------------------------------------
   // fifo use
   // ----------------------------------------

   // a pop needs a word held in the fifo toward the processor
   pl_pop_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      pl_pop_i |-> pl_count_i != '0)
   else $error("pop of the fifo toward the processor while empty");

   ps_yumi_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      ps_yumi_i |-> ps_v_i)
   else $error("yumi on the fifo toward the logic without valid");

endmodule

bind zynq_pl_shell zynq_pl_shell_props i_props (
   .S_AXI_ACLK   (S_AXI_ACLK),
   .S_AXI_ARESETN(S_AXI_ARESETN),
   .awready_i    (S_AXI_AWREADY),
   .arready_i    (S_AXI_ARREADY),
   .bvalid_i     (S_AXI_BVALID),
   .bready_i     (S_AXI_BREADY),
   .rvalid_i     (S_AXI_RVALID),
   .rready_i     (S_AXI_RREADY),
   .rdata_i      (S_AXI_RDATA),
   .pl_pop_i     (pl_pop),
   .pl_count_i   (pl_count),
   .ps_v_i       (ps_fifo_v_o),
   .ps_yumi_i    (ps_fifo_yumi_i)
);

`default_nettype wire

// ==== sim/tb_zynq_pl_shell.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_zynq_pl_shell
   import zynq_shell_pkg::*;
();

   localparam int timeout_lp = 50;

   logic S_AXI_ACLK;
   logic S_AXI_ARESETN;
   logic [addr_width_lp-1:0] awaddr;
   logic awvalid;
   logic awready;
   word_t wdata;
   logic wvalid;
   logic wready;
   logic [1:0] bresp;
   logic bvalid;
   logic bready;
   logic [addr_width_lp-1:0] araddr;
   logic arvalid;
   logic arready;
   word_t rdata;
   logic [1:0] rresp;
   logic rvalid;
   logic rready;
   word_t ps_data;
   logic ps_v;
   logic ps_yumi;
   word_t pl_data;
   logic pl_v;
   logic pl_ready;
   word_t [num_ctrl_regs_lp-1:0] csr_data;
   logic [num_ctrl_regs_lp-1:0] csr_new;
   word_t status;

   // ----------------------------------------
   // model and bookkeeping
   // ----------------------------------------

   word_t [num_ctrl_regs_lp-1:0] ctrl_m;
   word_t ps_q [$];
   word_t pl_q [$];
   int seed;
   int max_stall;
   string test_name;
   int test_checks;
   int test_errors;
   int total_checks;
   int total_errors;
   int tests_run;

   zynq_pl_shell i_dut (
      .S_AXI_ACLK     (S_AXI_ACLK),
      .S_AXI_ARESETN  (S_AXI_ARESETN),
      .S_AXI_AWADDR   (awaddr),
      .S_AXI_AWPROT   (3'b000),
      .S_AXI_AWVALID  (awvalid),
      .S_AXI_AWREADY  (awready),
      .S_AXI_WDATA    (wdata),
      .S_AXI_WSTRB    (4'hf),
      .S_AXI_WVALID   (wvalid),
      .S_AXI_WREADY   (wready),
      .S_AXI_BRESP    (bresp),
      .S_AXI_BVALID   (bvalid),
      .S_AXI_BREADY   (bready),
      .S_AXI_ARADDR   (araddr),
      .S_AXI_ARPROT   (3'b000),
      .S_AXI_ARVALID  (arvalid),
      .S_AXI_ARREADY  (arready),
      .S_AXI_RDATA    (rdata),
      .S_AXI_RRESP    (rresp),
      .S_AXI_RVALID   (rvalid),
      .S_AXI_RREADY   (rready),
      .ps_fifo_data_o (ps_data),
      .ps_fifo_v_o    (ps_v),
      .ps_fifo_yumi_i (ps_yumi),
      .pl_fifo_data_i (pl_data),
      .pl_fifo_v_i    (pl_v),
      .pl_fifo_ready_o(pl_ready),
      .csr_data_o     (csr_data),
      .csr_data_new_o (csr_new),
      .status_i       (status)
   );

   initial
   begin
      S_AXI_ACLK = 1'b0;
      forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
   end

   function automatic word_t next_random();
      next_random = $random(seed);
   endfunction

   function automatic int pick_below(input int n);
      word_t r;
      r = next_random();
      pick_below = int'(r % word_t'(n));
   endfunction

   task automatic expect_word(input string what, input word_t exp, input word_t act);
      test_checks++;
      assert (act === exp)
      else
      begin
         $display("Error: test %s: %s expected %h actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic expect_bit(input string what, input logic exp, input logic act);
      test_checks++;
      assert (act === exp)
      else
      begin
         $display("Error: test %s: %s expected %b actual %b", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout in test %s while waiting for %s", test_name, what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic finish_test();
      $display("test %s: %0d checks, %0d errors, %s", test_name, test_checks, test_errors,
               (test_errors == 0) ? "passed" : "failed");
      total_checks += test_checks;
      total_errors += test_errors;
      tests_run++;
   endtask

   // ----------------------------------------
   // bus transfers
   // ----------------------------------------

   // one AXI4-Lite write with the model updated at the handshake
   task automatic write_word(input word_idx_t idx, input word_t data);
      int n;
      int stall;
      word_t r;
      logic [num_ctrl_regs_lp-1:0] new_exp;
      new_exp = '0;
      if (idx == wr_ctrl0_lp)
         new_exp[0] = 1'b1;
      if (idx == wr_ctrl1_lp)
         new_exp[1] = 1'b1;
      r = next_random();
      @(negedge S_AXI_ACLK);
      // random byte offset bits that the shell ignores
      awaddr = {idx, r[addr_lsb_lp-1:0]};
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      n = 0;
      while (!awready)
      begin
         if (n == timeout_lp)
            abort_on_timeout("AWREADY");
         @(negedge S_AXI_ACLK);
         n++;
      end
      expect_bit("WREADY with AWREADY", 1'b1, wready);
      @(negedge S_AXI_ACLK);
      awvalid = 1'b0;
      wvalid = 1'b0;
      if (idx == wr_ctrl0_lp || idx == wr_ctrl1_lp)
         ctrl_m[idx[0]] = data;
      else if (idx == wr_ps_fifo_push_lp && ps_q.size() < fifo_depth_lp)
         ps_q.push_back(data);
      // response, new pulse and register value all land in this cycle
      expect_bit("BVALID after handshake", 1'b1, bvalid);
      expect_word("BRESP", word_t'(resp_okay_lp), word_t'(bresp));
      expect_word("csr_data_new_o at BVALID rise", word_t'(new_exp), word_t'(csr_new));
      expect_word("csr_data_o[0]", ctrl_m[0], csr_data[0]);
      expect_word("csr_data_o[1]", ctrl_m[1], csr_data[1]);
      expect_bit("ps_fifo_v_o after write", ps_q.size() > 0, ps_v);
      stall = pick_below(max_stall + 1);
      repeat (stall)
      begin
         @(negedge S_AXI_ACLK);
         expect_bit("BVALID held under stall", 1'b1, bvalid);
         expect_word("csr_data_new_o after pulse", '0, word_t'(csr_new));
      end
      bready = 1'b1;
      @(negedge S_AXI_ACLK);
      bready = 1'b0;
      expect_bit("BVALID after BREADY", 1'b0, bvalid);
      expect_word("csr_data_new_o after response", '0, word_t'(csr_new));
   endtask

   // one AXI4-Lite read with RDATA held while RREADY is low
   task automatic read_word(input word_idx_t idx, output word_t data);
      int n;
      int stall;
      word_t r;
      r = next_random();
      @(negedge S_AXI_ACLK);
      araddr = {idx, r[addr_lsb_lp-1:0]};
      arvalid = 1'b1;
      n = 0;
      while (!arready)
      begin
         if (n == timeout_lp)
            abort_on_timeout("ARREADY");
         @(negedge S_AXI_ACLK);
         n++;
      end
      @(negedge S_AXI_ACLK);
      arvalid = 1'b0;
      expect_bit("RVALID after handshake", 1'b1, rvalid);
      expect_word("RRESP", word_t'(resp_okay_lp), word_t'(rresp));
      data = rdata;
      stall = pick_below(max_stall + 1);
      repeat (stall)
      begin
         @(negedge S_AXI_ACLK);
         expect_bit("RVALID held under stall", 1'b1, rvalid);
         expect_word("RDATA held under stall", data, rdata);
      end
      rready = 1'b1;
      @(negedge S_AXI_ACLK);
      rready = 1'b0;
      expect_bit("RVALID after RREADY", 1'b0, rvalid);
   endtask

   task automatic read_and_expect(input string what, input word_idx_t idx, input word_t exp);
      word_t got;
      read_word(idx, got);
      expect_word(what, exp, got);
   endtask

   // ----------------------------------------
   // logic side drivers
   // ----------------------------------------

   // random yumi on the fifo toward the logic whenever the model holds a word
   task automatic drain_ps_fifo(input int cycles);
      repeat (cycles)
      begin
         @(negedge S_AXI_ACLK);
         expect_bit("ps_fifo_v_o", ps_q.size() > 0, ps_v);
         if (ps_q.size() > 0)
            expect_word("ps_fifo_data_o", ps_q[0], ps_data);
         ps_yumi = (ps_q.size() > 0) && (pick_below(2) == 1);
         if (ps_yumi)
            void'(ps_q.pop_front());
      end
      @(negedge S_AXI_ACLK);
      ps_yumi = 1'b0;
   endtask

   // random valid on the fifo toward the processor
   task automatic feed_pl_fifo(input int cycles);
      repeat (cycles)
      begin
         @(negedge S_AXI_ACLK);
         expect_bit("pl_fifo_ready_o", pl_q.size() < fifo_depth_lp, pl_ready);
         pl_v = (pick_below(2) == 1);
         pl_data = next_random();
         if (pl_v && pl_q.size() < fifo_depth_lp)
            pl_q.push_back(pl_data);
      end
      @(negedge S_AXI_ACLK);
      pl_v = 1'b0;
   endtask

   task automatic check_counts();
      read_and_expect("pl fifo count", rd_pl_fifo_count_lp, word_t'(pl_q.size()));
      read_and_expect("ps fifo free", rd_ps_fifo_free_lp,
                      word_t'(fifo_depth_lp - ps_q.size()));
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------

   initial
   begin
      int k;
      int op;
      word_idx_t idx;
      seed = 32'hf10dd493;
      max_stall = 2;
      total_checks = 0;
      total_errors = 0;
      tests_run = 0;
      ctrl_m = '0;
      S_AXI_ARESETN = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      ps_yumi = 1'b0;
      pl_data = '0;
      pl_v = 1'b0;
      status = '0;
      repeat (3) @(posedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      S_AXI_ARESETN = 1'b1;

      begin_test("reset");
      @(negedge S_AXI_ACLK);
      expect_bit("AWREADY", 1'b0, awready);
      expect_bit("WREADY", 1'b0, wready);
      expect_bit("BVALID", 1'b0, bvalid);
      expect_bit("ARREADY", 1'b0, arready);
      expect_bit("RVALID", 1'b0, rvalid);
      expect_word("csr_data_new_o", '0, word_t'(csr_new));
      expect_bit("ps_fifo_v_o", 1'b0, ps_v);
      expect_bit("pl_fifo_ready_o", 1'b1, pl_ready);
      read_and_expect("ctrl0", rd_ctrl0_lp, '0);
      read_and_expect("ctrl1", rd_ctrl1_lp, '0);
      finish_test();

      begin_test("control registers");
      repeat (12)
      begin
         idx = word_idx_t'(pick_below(num_ctrl_regs_lp));
         write_word(idx, next_random());
         read_and_expect("ctrl read-back", idx, ctrl_m[idx[0]]);
      end
      finish_test();

      begin_test("ps fifo");
      repeat (5)
      begin
         // up to 6 pushes, so a full fifo drops some
         k = pick_below(7);
         repeat (k) write_word(wr_ps_fifo_push_lp, next_random());
         check_counts();
         drain_ps_fifo(pick_below(8));
         check_counts();
      end
      drain_ps_fifo(12);
      check_counts();
      finish_test();

      begin_test("pl fifo");
      repeat (5)
      begin
         feed_pl_fifo(pick_below(9));
         check_counts();
         k = pick_below(pl_q.size() + 1);
         repeat (k) read_and_expect("pl fifo head", rd_pl_fifo_head_lp, pl_q.pop_front());
         check_counts();
      end
      while (pl_q.size() > 0)
         read_and_expect("pl fifo head", rd_pl_fifo_head_lp, pl_q.pop_front());
      check_counts();
      finish_test();

      begin_test("status and unmapped");
      @(negedge S_AXI_ACLK);
      status = next_random();
      read_and_expect("status", rd_status_lp, status);
      read_and_expect("index 6", word_idx_t'(6), '0);
      read_and_expect("index 7", word_idx_t'(7), '0);
      for (int j = 3; j < 8; j++)
         write_word(word_idx_t'(j), next_random());
      read_and_expect("ctrl0", rd_ctrl0_lp, ctrl_m[0]);
      read_and_expect("ctrl1", rd_ctrl1_lp, ctrl_m[1]);
      check_counts();
      finish_test();

      begin_test("back-pressure");
      max_stall = 8;
      repeat (16)
      begin
         op = pick_below(4);
         idx = word_idx_t'(pick_below(num_ctrl_regs_lp));
         case (op)
            0: write_word(idx, next_random());
            1: read_and_expect("ctrl read-back", idx, ctrl_m[idx[0]]);
            2: write_word(wr_ps_fifo_push_lp, next_random());
            default: check_counts();
         endcase
      end
      drain_ps_fifo(12);
      check_counts();
      finish_test();

      $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
      if (total_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
common/zynq_shell_pkg.sv
hw/axil/axil_write_channel.sv
hw/axil/axil_read_channel.sv
hw/word_fifo.sv
hw/csr_map.sv
hw/zynq_pl_shell.sv
sim/zynq_pl_shell_props.sv
sim/tb_zynq_pl_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_zynq_pl_shell -f files.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
